// File: dram_ctrl.f
+incdir+hdl
hdl/dram_addr_pkg.sv
hdl/dram_cmd_pkg.sv
hdl/dram_fifo.sv
hdl/dram_serdes.sv
hdl/dram_refresh_timer.sv
hdl/dram_ctrl_fsm.sv
hdl/dram_ctrl.sv
sim/tb_dram_ctrl.sv

// File: sim/tb_dram_ctrl.sv
/*
 * Testbench for the DRAM controller. Random L2 traffic runs against a
 * behavioral DRAM device with random ack delays and a read scoreboard.
 */
`include "dram_cfg.svh"

module tb_dram_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    import dram_addr_pkg::*;
    import dram_cmd_pkg::*;

    localparam integer NUM_REQS     = 150;
    localparam integer POOL_SIZE    = 12;
    localparam integer MAX_SEQ      = 64; // worst case cycles of one command sequence
    localparam integer REFRESH_GAP  = 2 * `DRAM_REFRESH_INTERVAL + MAX_SEQ;
    localparam integer DONE_TIMEOUT = 20000;

    logic      clk;
    logic      reset;
    logic      l2_req_wr;
    l2_req_t   l2_req;
    logic      l2_req_full;
    logic      l2_rsp_rd;
    l2_data_t  l2_rsp_data;
    logic      l2_rsp_empty;
    logic      cmd_req;
    logic      cmd_ack;
    dram_cmd_t dram_cmd;
    logic      dram_wdata;
    logic      dram_rdata;

    integer     seed;
    integer     dev_seed;
    dram_addr_t addr_pool [POOL_SIZE];
    l2_data_t   ref_mem [2**13]; // what L2 expects, in request order
    l2_data_t   dev_mem [2**13]; // device contents
    l2_req_t    exp_q [$];
    l2_data_t   sb [$];          // expected read bytes
    logic       traffic_on;
    logic       full_seen;
    integer     issued;
    integer     reads;
    integer     responses;
    integer     activates;
    integer     seqs_done;

    // device model state
    dram_cmd_t cur;
    logic      pend;
    logic      row_open;
    logic      rw_done;
    logic      drop_due;
    integer    delay;
    integer    wr_left;
    integer    rd_left;
    integer    since_refresh;
    l2_data_t  wr_shift;
    l2_data_t  rd_shift;

    dram_ctrl i_dram_ctrl (
        .clk          (clk),
        .reset        (reset),
        .l2_req_wr    (l2_req_wr),
        .l2_req       (l2_req),
        .l2_req_full  (l2_req_full),
        .l2_rsp_rd    (l2_rsp_rd),
        .l2_rsp_data  (l2_rsp_data),
        .l2_rsp_empty (l2_rsp_empty),
        .cmd_req      (cmd_req),
        .cmd_ack      (cmd_ack),
        .dram_cmd     (dram_cmd),
        .dram_wdata   (dram_wdata),
        .dram_rdata   (dram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic check_cmd(input dram_cmd_t got, input dram_cmd_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %s addr %h, expected %s addr %h",
                     $time, what, got.cmd.name(), got.addr, exp.cmd.name(), exp.addr);
            end_in_failure();
        end
    endtask

    task automatic check_data(input l2_data_t got, input l2_data_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    // initial memory contents, a mix of all address bits
    function automatic l2_data_t fill_byte(input dram_addr_t a);
        logic [12:0] v;
        v = a;
        return v[7:0] ^ {v[12:8], v[2:0]} ^ 8'h5a;
    endfunction

    function automatic dram_cmd_t make_cmd(input dram_cmd_e c, input dram_addr_t a);
        dram_cmd_t r;
        r.cmd  = c;
        r.addr = a;
        return r;
    endfunction

    // L2 side: random requests and random response pops, at most one per two cycles
    always @(posedge clk) begin : l2_side
        l2_req_t r;
        if (reset) begin
            l2_req_wr <= 1'b0;
            l2_rsp_rd <= 1'b0;
        end else begin
            l2_req_wr <= 1'b0;
            l2_rsp_rd <= 1'b0;
            if (traffic_on && issued < NUM_REQS && !l2_req_wr && !l2_req_full
                    && ($unsigned($random(seed)) % 4 != 0)) begin
                r.wr   = $random(seed);
                r.addr = addr_pool[$unsigned($random(seed)) % POOL_SIZE];
                r.data = $random(seed);
                if (r.wr) begin
                    ref_mem[r.addr] = r.data;
                end else begin
                    sb.push_back(ref_mem[r.addr]);
                    reads++;
                end
                exp_q.push_back(r);
                issued++;
                l2_req    <= r;
                l2_req_wr <= 1'b1;
            end
            if (!l2_rsp_rd && !l2_rsp_empty && $random(seed) % 2 != 0) begin
                if (sb.size() == 0)
                    abort_run("response data with no read outstanding");
                check_data(l2_rsp_data, sb.pop_front(), "read response");
                responses++;
                l2_rsp_rd <= 1'b1;
            end
        end
    end

    // DRAM device: random ack delay, serial data, command order checks
    always @(posedge clk) begin : device
        dram_cmd_t got;
        dram_cmd_t exp;
        if (reset) begin
            cmd_ack       <= 1'b0;
            dram_rdata    <= 1'b0;
            pend          = 1'b0;
            row_open      = 1'b0;
            rw_done       = 1'b0;
            drop_due      = 1'b0;
            wr_left       = 0;
            rd_left       = 0;
            since_refresh = 0;
        end else begin
            cmd_ack <= 1'b0;
            since_refresh++;
            if (since_refresh > REFRESH_GAP)
                abort_run("no REFRESH command within the refresh window");
            if (wr_left > 0) begin
                wr_shift = {wr_shift[6:0], dram_wdata}; // MSB arrives first
                wr_left--;
                if (wr_left == 0) begin
                    check_data(wr_shift, exp_q[0].data, "serial write data");
                    dev_mem[exp_q[0].addr] = wr_shift;
                end
            end
            if (rd_left > 0) begin
                rd_shift = rd_shift << 1;
                dram_rdata <= rd_shift[7];
                rd_left--;
            end
            if (drop_due && cmd_req)
                abort_run("cmd_req still high the cycle after cmd_ack");
            drop_due = 1'b0;
            if (cmd_ack) begin
                case (cur.cmd)
                    ACTIVATE: row_open = 1'b1;
                    READ: begin
                        rd_shift = dev_mem[cur.addr];
                        dram_rdata <= rd_shift[7];
                        rd_left = 7;
                        rw_done = 1'b1;
                    end
                    WRITE: begin
                        wr_left = 8;
                        rw_done = 1'b1;
                    end
                    PRECHARGE: begin
                        row_open = 1'b0;
                        rw_done  = 1'b0;
                        void'(exp_q.pop_front());
                        seqs_done++;
                    end
                    default: ;
                endcase
                pend     = 1'b0;
                drop_due = 1'b1;
            end else if (cmd_req) begin
                if (!pend) begin
                    got = dram_cmd;
                    if (!row_open && got.cmd == REFRESH) begin
                        check_cmd(got, make_cmd(REFRESH, '0), "refresh command");
                        since_refresh = 0;
                    end else begin
                        if (exp_q.size() == 0)
                            abort_run("command issued with no request outstanding");
                        if (!row_open)
                            exp = make_cmd(ACTIVATE, exp_q[0].addr);
                        else if (!rw_done)
                            exp = make_cmd(exp_q[0].wr ? WRITE : READ, exp_q[0].addr);
                        else
                            exp = make_cmd(PRECHARGE, exp_q[0].addr);
                        check_cmd(got, exp, "command sequence");
                        if (got.cmd == PRECHARGE && (wr_left > 0 || rd_left > 0))
                            abort_run("PRECHARGE issued before the data transfer ended");
                        if (got.cmd == ACTIVATE)
                            activates++;
                    end
                    cur   = got;
                    pend  = 1'b1;
                    delay = $unsigned($random(dev_seed)) % 6;
                end else begin
                    check_cmd(dram_cmd, cur, "dram_cmd held while cmd_req is high");
                end
                if (delay == 0)
                    cmd_ack <= 1'b1;
                else
                    delay--;
            end
        end
    end

    // request FIFO occupancy against l2_req_full, at most one popped request in flight
    always @(negedge clk) begin : full_check
        integer outstanding;
        if (!reset) begin
            outstanding = issued - (l2_req_wr ? 1 : 0) - activates;
            if (l2_req_full) begin
                full_seen = 1'b1;
                if (outstanding < `DRAM_FIFO_DEPTH)
                    abort_run("l2_req_full high with fewer than 8 requests queued");
            end else if (outstanding > `DRAM_FIFO_DEPTH) begin
                abort_run("l2_req_full low with 8 requests queued");
            end
        end
    end

    initial begin : main
        integer i;
        integer wait_cycles;
        seed       = 93131;
        dev_seed   = $random(seed);
        reset      = 1'b1;
        l2_req_wr  = 1'b0;
        l2_req     = '0;
        l2_rsp_rd  = 1'b0;
        cmd_ack    = 1'b0;
        dram_rdata = 1'b0;
        traffic_on = 1'b0;
        full_seen  = 1'b0;
        issued     = 0;
        reads      = 0;
        responses  = 0;
        activates  = 0;
        seqs_done  = 0;
        for (i = 0; i < 2**13; i++) begin
            ref_mem[i] = fill_byte(dram_addr_t'(i));
            dev_mem[i] = fill_byte(dram_addr_t'(i));
        end
        for (i = 0; i < POOL_SIZE; i++)
            addr_pool[i] = dram_addr_t'($random(seed));

        repeat (10) @(posedge clk);
        check_cmd(dram_cmd, make_cmd(NOP, '0), "dram_cmd in reset");
        if (cmd_req !== 1'b0 || dram_wdata !== 1'b0)
            abort_run("cmd_req or dram_wdata not low in reset");
        if (l2_rsp_empty !== 1'b1 || l2_req_full !== 1'b0)
            abort_run("FIFO flags not at their reset values");
        reset      <= 1'b0;
        traffic_on <= 1'b1;

        wait_cycles = 0;
        while (seqs_done < NUM_REQS || !l2_rsp_empty) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > DONE_TIMEOUT)
                abort_run("timeout waiting for all requests to complete");
        end

        if (responses != reads) begin
            abort_run("response count differs from read count");
        end else if (!full_seen) begin
            abort_run("l2_req_full never rose under load");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: hdl/dram_ctrl.sv
/*
 * DRAM controller top level. L2 requests queue in req_fifo, the FSM
 * runs one command sequence per request, read bytes return through rsp_fifo.
 */
`include "dram_cfg.svh"

module dram_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    l2_req_wr,
    input  dram_addr_pkg::l2_req_t  l2_req,
    output logic                    l2_req_full,
    input  logic                    l2_rsp_rd,
    output dram_addr_pkg::l2_data_t l2_rsp_data,
    output logic                    l2_rsp_empty,
    output logic                    cmd_req,
    input  logic                    cmd_ack,
    output dram_cmd_pkg::dram_cmd_t dram_cmd,
    output logic                    dram_wdata,
    input  logic                    dram_rdata
);

    import dram_addr_pkg::*;

    l2_req_t  req_head; // oldest queued request
    l2_data_t wr_byte_q; // write byte of the popped request held until the WRITE ack
    l2_data_t rd_byte;
    logic     req_empty;
    logic     req_pop;
    logic     rsp_full;
    logic     rsp_push;
    logic     refresh_due;
    logic     refresh_clr;
    logic     ser_start;
    logic     des_start;
    logic     xfer_done;

    dram_fifo #(
        .payload_t (l2_req_t),
        .DEPTH     (`DRAM_FIFO_DEPTH)
    ) req_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr      (l2_req_wr),
        .wr_data (l2_req),
        .rd      (req_pop),
        .rd_data (req_head),
        .empty   (req_empty),
        .full    (l2_req_full)
    );

    dram_fifo #(
        .payload_t (l2_data_t),
        .DEPTH     (`DRAM_FIFO_DEPTH)
    ) rsp_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr      (rsp_push),
        .wr_data (rd_byte),
        .rd      (l2_rsp_rd),
        .rd_data (l2_rsp_data),
        .empty   (l2_rsp_empty),
        .full    (rsp_full)
    );

    always_ff @(posedge clk) begin
        if (req_pop)
            wr_byte_q <= req_head.data;
    end

    dram_serdes i_serdes (
        .clk        (clk),
        .reset      (reset),
        .ser_start  (ser_start),
        .des_start  (des_start),
        .wr_byte    (wr_byte_q),
        .dram_wdata (dram_wdata),
        .dram_rdata (dram_rdata),
        .rd_byte    (rd_byte),
        .xfer_done  (xfer_done)
    );

    dram_refresh_timer i_refresh_timer (
        .clk         (clk),
        .reset       (reset),
        .refresh_clr (refresh_clr),
        .refresh_due (refresh_due)
    );

    dram_ctrl_fsm i_fsm (
        .clk         (clk),
        .reset       (reset),
        .req_empty   (req_empty),
        .req_pop     (req_pop),
        .req         (req_head),
        .rsp_full    (rsp_full),
        .rsp_push    (rsp_push),
        .refresh_due (refresh_due),
        .refresh_clr (refresh_clr),
        .ser_start   (ser_start),
        .des_start   (des_start),
        .xfer_done   (xfer_done),
        .cmd_req     (cmd_req),
        .cmd_ack     (cmd_ack),
        .dram_cmd    (dram_cmd)
    );

endmodule

// File: hdl/dram_ctrl_fsm.sv
/*
 * Command sequencer. Per request it issues ACTIVATE, READ or WRITE,
 * waits for the serial transfer, then PRECHARGE. Pending refresh is
 * served from idle, before the next request is taken.
 */
module dram_ctrl_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_empty,
    output logic                     req_pop,
    input  dram_addr_pkg::l2_req_t   req,
    input  logic                     rsp_full,
    output logic                     rsp_push,
    input  logic                     refresh_due,
    output logic                     refresh_clr,
    output logic                     ser_start,
    output logic                     des_start,
    input  logic                     xfer_done,
    output logic                     cmd_req,
    input  logic                     cmd_ack,
    output dram_cmd_pkg::dram_cmd_t  dram_cmd
);

    import dram_addr_pkg::*;
    import dram_cmd_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REFRESH,
        S_ACT,
        S_RW,
        S_XFER,
        S_PRE
    } state_e;

    state_e  state_q;
    state_e  state_d;
    l2_req_t req_q;   // request being served
    logic    ack_hit;
    logic    cmd_state;

    assign ack_hit   = cmd_req && cmd_ack;
    assign cmd_state = (state_q == S_REFRESH) || (state_q == S_ACT) ||
                       (state_q == S_RW) || (state_q == S_PRE);

    always_comb begin
        state_d     = state_q;
        req_pop     = 1'b0;
        refresh_clr = 1'b0;
        ser_start   = 1'b0;
        des_start   = 1'b0;
        rsp_push    = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (refresh_due) begin // refresh goes first
                    refresh_clr = 1'b1;
                    state_d     = S_REFRESH;
                end else if (!req_empty && !rsp_full) begin
                    req_pop = 1'b1;
                    state_d = S_ACT;
                end
            end
            S_REFRESH: if (ack_hit) state_d = S_IDLE;
            S_ACT:     if (ack_hit) state_d = S_RW;
            S_RW: begin
                if (ack_hit) begin
                    ser_start = req_q.wr;
                    des_start = !req_q.wr;
                    state_d   = S_XFER;
                end
            end
            S_XFER: begin
                if (xfer_done) begin
                    rsp_push = !req_q.wr;
                    state_d  = S_PRE;
                end
            end
            S_PRE:     if (ack_hit) state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            cmd_req <= 1'b0;
        end else begin
            state_q <= state_d;
            // raise one cycle into a command state, drop after the ack
            cmd_req <= cmd_state && !ack_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop)
            req_q <= req;
    end

    always_comb begin
        dram_cmd.addr = req_q.addr;
        case (state_q)
            S_ACT:     dram_cmd.cmd = ACTIVATE;
            S_RW:      dram_cmd.cmd = req_q.wr ? WRITE : READ;
            S_PRE:     dram_cmd.cmd = PRECHARGE;
            S_REFRESH: dram_cmd.cmd = REFRESH;
            default:   dram_cmd.cmd = NOP;
        endcase
        if (dram_cmd.cmd == NOP || dram_cmd.cmd == REFRESH)
            dram_cmd.addr = '0;
    end

endmodule

// File: hdl/dram_refresh_timer.sv
/*
 * Free-running refresh interval counter. refresh_due stays set
 * until the FSM clears it with refresh_clr.
 */
`include "dram_cfg.svh"

module dram_refresh_timer (
    input  logic clk,
    input  logic reset,
    input  logic refresh_clr,
    output logic refresh_due
);

    localparam integer CNT_W = $clog2(`DRAM_REFRESH_INTERVAL);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q       <= '0;
            refresh_due <= 1'b0;
        end else if (cnt_q == CNT_W'(`DRAM_REFRESH_INTERVAL - 1)) begin
            cnt_q       <= '0;
            refresh_due <= 1'b1; // a new interval wins over a clear
        end else begin
            cnt_q <= cnt_q + 1'b1;
            if (refresh_clr)
                refresh_due <= 1'b0;
        end
    end

endmodule

// File: hdl/dram_serdes.sv
/*
 * Bit-serial data path to the DRAM device, MSB first.
 * ser_start loads a write byte and shifts it out, des_start collects
 * a read byte from dram_rdata. xfer_done pulses the cycle after the last bit.
 */
`include "dram_cfg.svh"

module dram_serdes (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ser_start,
    input  logic                   des_start,
    input  dram_addr_pkg::l2_data_t wr_byte,
    output logic                   dram_wdata,
    input  logic                   dram_rdata,
    output dram_addr_pkg::l2_data_t rd_byte,
    output logic                   xfer_done
);

    import dram_addr_pkg::*;

    localparam integer W     = `DRAM_DATA_WIDTH;
    localparam integer CNT_W = $clog2(W);

    l2_data_t         shift_q;
    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    logic             wr_mode_q; // 1 while serializing
    logic             done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q    <= 1'b0;
            wr_mode_q <= 1'b0;
            cnt_q     <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (ser_start || des_start) begin
                busy_q    <= 1'b1;
                wr_mode_q <= ser_start;
                cnt_q     <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(W - 1)) begin // eighth bit moved
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ser_start)
            shift_q <= wr_byte;
        else if (busy_q)
            shift_q <= {shift_q[W-2:0], wr_mode_q ? 1'b0 : dram_rdata};
    end

    assign dram_wdata = busy_q && wr_mode_q && shift_q[W-1];
    assign rd_byte    = shift_q;
    assign xfer_done  = done_q;

endmodule

// File: hdl/dram_fifo.sv
/*
 * Synchronous show-ahead FIFO. rd_data always shows the oldest entry,
 * rd pops it. Writes while full and reads while empty are ignored.
 */
module dram_fifo #(
    parameter type    payload_t = logic [7:0],
    parameter integer DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr,
    input  payload_t wr_data,
    input  logic     rd,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam integer PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam integer CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr != do_rd)
                count <= do_wr ? count + 1'b1 : count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));

endmodule

// File: hdl/dram_cmd_pkg.sv
/*
 * Command encoding and the command word presented to the DRAM device
 * together with cmd_req.
 */
`include "dram_cfg.svh"

package dram_cmd_pkg;

    typedef enum logic [2:0] {
        NOP       = 3'd0,
        ACTIVATE  = 3'd1,
        READ      = 3'd2,
        WRITE     = 3'd3,
        PRECHARGE = 3'd4,
        REFRESH   = 3'd5
    } dram_cmd_e;

    typedef struct packed {
        dram_cmd_e               cmd;
        dram_addr_pkg::dram_addr_t addr; // zero for REFRESH
    } dram_cmd_t; // 16 bits

endpackage

// File: hdl/dram_addr_pkg.sv
/*
 * Address, L2 request and L2 response types.
 * Shared by the top level, the FSM, the serdes and the testbench.
 */
`include "dram_cfg.svh"

package dram_addr_pkg;

    typedef struct packed {
        logic [`DRAM_BANK_BITS-1:0] bank;
        logic [`DRAM_ROW_BITS-1:0]  row;
        logic [`DRAM_COL_BITS-1:0]  col;
    } dram_addr_t; // 13 bits

    typedef logic [`DRAM_DATA_WIDTH-1:0] l2_data_t;

    // same 22 bit width as the legacy L2 request word
    typedef struct packed {
        logic       wr;   // 1 = write, 0 = read
        dram_addr_t addr;
        l2_data_t   data; // write data, ignored on reads
    } l2_req_t;

endpackage

// File: hdl/dram_cfg.svh
/*
 * Sizing and timing constants for the DRAM controller.
 * Included by the packages and by any module that needs a width or a depth.
 */
`ifndef DRAM_CFG_SVH
`define DRAM_CFG_SVH

`define DRAM_BANK_BITS        3
`define DRAM_ROW_BITS         7
`define DRAM_COL_BITS         3
// one byte per access, also the serial burst length
`define DRAM_DATA_WIDTH       8
`define DRAM_FIFO_DEPTH       8
`define DRAM_REFRESH_INTERVAL 200

`endif
